// ==== design/vec_cfg_pkg.sv ====
package vec_cfg_pkg;

  ////////////////////
  // Vector sizes
  ////////////////////

  // Element width in bits
  localparam int unsigned ELEN = 32;
  // Elements per vector register
  localparam int unsigned VLMAX = 8;
  localparam int unsigned NR_VREGS = 8;
  localparam int unsigned VREG_IDX_W = 3;
  // Holds 0 to VLMAX inclusive
  localparam int unsigned VL_W = 4;

  ////////////////////
  // Response queue
  ////////////////////

  localparam int unsigned RESP_FIFO_DEPTH = 2;
  localparam int unsigned RESP_PTR_W = (RESP_FIFO_DEPTH > 1) ? $clog2(RESP_FIFO_DEPTH) : 1;
  localparam int unsigned RESP_CNT_W = $clog2(RESP_FIFO_DEPTH + 1);

  // Common word types
  typedef logic [ELEN-1:0] elem_t;
  typedef logic [VL_W-1:0] vl_t;
  typedef logic [VREG_IDX_W-1:0] vreg_idx_t;
  typedef logic [RESP_PTR_W-1:0] resp_ptr_t;
  typedef logic [RESP_CNT_W-1:0] resp_cnt_t;

endpackage

// ==== design/vec_isa_pkg.sv ====
package vec_isa_pkg;

  typedef enum logic [1:0] {
    KIND_SETVL  = 2'd0,
    KIND_ARITH  = 2'd1,
    KIND_REDSUM = 2'd2,
    KIND_MOVX   = 2'd3
  } insn_kind_e;

  typedef enum logic [2:0] {
    OP_ADD = 3'd0,
    OP_SUB = 3'd1,
    OP_AND = 3'd2,
    OP_OR  = 3'd3,
    OP_XOR = 3'd4,
    OP_MV  = 3'd5
  } alu_op_e;

  ////////////////////
  // Instruction word
  ////////////////////

  // Kind sits in the top two bits of both views
  typedef struct packed {
    insn_kind_e             kind;
    alu_op_e                op;
    vec_cfg_pkg::vreg_idx_t vd;
    vec_cfg_pkg::vreg_idx_t vs1;
    vec_cfg_pkg::vreg_idx_t vs2;
    logic                   scalar_op;
    logic [16:0]            pad;
  } insn_arith_t;

  typedef struct packed {
    insn_kind_e  kind;
    logic [4:0]  avl;
    logic [24:0] pad;
  } insn_cfg_t;

  typedef union packed {
    insn_arith_t arith;
    insn_cfg_t   cfg;
  } vec_insn_u;

  ////////////////////
  // Channels
  ////////////////////

  typedef struct packed {
    vec_insn_u          insn;
    vec_cfg_pkg::elem_t rs1;
  } acc_req_t;

  // Dispatcher to lane
  typedef struct packed {
    insn_kind_e             kind;
    alu_op_e                op;
    vec_cfg_pkg::vreg_idx_t vd;
    vec_cfg_pkg::vreg_idx_t vs1;
    vec_cfg_pkg::vreg_idx_t vs2;
    logic                   scalar_op;
    vec_cfg_pkg::elem_t     scalar;
    vec_cfg_pkg::vl_t       vl;
  } vec_issue_t;

  // Lane to result unit, one beat per element
  typedef struct packed {
    insn_kind_e         kind;
    vec_cfg_pkg::elem_t data;
    logic               last;
  } elem_res_t;

  typedef struct packed {
    insn_kind_e         kind;
    vec_cfg_pkg::elem_t data;
  } acc_resp_t;

endpackage

// ==== design/vec_alu.sv ====
module vec_alu (
  input  vec_isa_pkg::alu_op_e op_i,
  // a is the vs2 element, b the vs1 element or scalar
  input  vec_cfg_pkg::elem_t   a_i,
  input  vec_cfg_pkg::elem_t   b_i,
  output vec_cfg_pkg::elem_t   res_o
);

  always_comb begin
    case (op_i)
      vec_isa_pkg::OP_ADD: begin
        res_o = a_i + b_i;
      end
      vec_isa_pkg::OP_SUB: begin
        res_o = a_i - b_i;
      end
      vec_isa_pkg::OP_AND: begin
        res_o = a_i & b_i;
      end
      vec_isa_pkg::OP_OR: begin
        res_o = a_i | b_i;
      end
      vec_isa_pkg::OP_XOR: begin
        res_o = a_i ^ b_i;
      end
      // Splat or copy
      vec_isa_pkg::OP_MV: begin
        res_o = b_i;
      end
      default: begin
        res_o = '0;
      end
    endcase
  end

endmodule

// ==== design/vec_dispatcher.sv ====
module vec_dispatcher (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  // Host request channel
  input  vec_isa_pkg::acc_req_t   acc_req_i,
  input  logic                    acc_req_valid_i,
  output logic                    acc_req_ready_o,
  // Issue channel to the lane
  output vec_isa_pkg::vec_issue_t issue_o,
  output logic                    issue_valid_o,
  input  logic                    issue_ready_i
);

  vec_cfg_pkg::vl_t        vl_q;
  vec_cfg_pkg::vl_t        new_vl;
  vec_isa_pkg::vec_issue_t issue_d;
  vec_isa_pkg::vec_issue_t issue_q;
  logic                    issue_valid_q;
  logic                    req_hs;

  // Take a new request when the issue slot frees up this cycle
  assign acc_req_ready_o = !issue_valid_q || issue_ready_i;
  assign req_hs          = acc_req_valid_i && acc_req_ready_o;

  ////////////////////
  // Decode
  ////////////////////

  always_comb begin
    vec_isa_pkg::insn_arith_t arith;
    vec_isa_pkg::insn_cfg_t   cfg;

    arith = acc_req_i.insn.arith;
    cfg   = acc_req_i.insn.cfg;

    // Clamp requested length
    if (cfg.avl > vec_cfg_pkg::VLMAX) begin
      new_vl = vec_cfg_pkg::vl_t'(vec_cfg_pkg::VLMAX);
    end else begin
      new_vl = vec_cfg_pkg::vl_t'(cfg.avl);
    end

    issue_d        = '0;
    issue_d.kind   = arith.kind;
    issue_d.scalar = acc_req_i.rs1;
    issue_d.vl     = vl_q;
    if (arith.kind == vec_isa_pkg::KIND_SETVL) begin
      issue_d.vl = new_vl;
    end else begin
      issue_d.op        = arith.op;
      issue_d.vd        = arith.vd;
      issue_d.vs1       = arith.vs1;
      issue_d.vs2       = arith.vs2;
      issue_d.scalar_op = arith.scalar_op;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      vl_q          <= vec_cfg_pkg::vl_t'(vec_cfg_pkg::VLMAX);
      issue_valid_q <= 1'b0;
    end else begin
      if (req_hs) begin
        issue_valid_q <= 1'b1;
      end else if (issue_ready_i) begin
        issue_valid_q <= 1'b0;
      end
      if (req_hs && issue_d.kind == vec_isa_pkg::KIND_SETVL) begin
        vl_q <= new_vl;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_hs) begin
      issue_q <= issue_d;
    end
  end

  assign issue_o       = issue_q;
  assign issue_valid_o = issue_valid_q;

  // Stalled issue holds its value
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    issue_valid_o && !issue_ready_i |=> issue_valid_o && $stable(issue_o));

endmodule

// ==== design/vec_lane.sv ====
module vec_lane (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  // Issue channel from the dispatcher
  input  vec_isa_pkg::vec_issue_t issue_i,
  input  logic                    issue_valid_i,
  output logic                    issue_ready_o,
  // Element channel to the result unit
  output vec_isa_pkg::elem_res_t  elem_o,
  output logic                    elem_valid_o,
  input  logic                    elem_ready_i
);

  typedef struct packed {
    vec_cfg_pkg::vreg_idx_t vd;
    vec_cfg_pkg::vl_t       idx;
    vec_cfg_pkg::elem_t     data;
  } wb_t;

  vec_cfg_pkg::elem_t [vec_cfg_pkg::NR_VREGS-1:0][vec_cfg_pkg::VLMAX-1:0] vrf_q;

  vec_isa_pkg::vec_issue_t cur_q;
  logic                    busy_q;
  vec_cfg_pkg::vl_t        idx_q;
  wb_t                     wb_q;
  logic                    wb_valid_q;

  vec_cfg_pkg::elem_t   vs1_elem;
  vec_cfg_pkg::elem_t   vs2_elem;
  vec_cfg_pkg::elem_t   alu_a;
  vec_cfg_pkg::elem_t   alu_b;
  vec_cfg_pkg::elem_t   alu_res;
  vec_isa_pkg::alu_op_e alu_op;
  logic                 in_range;
  logic                 last;
  logic                 reads_vs1;
  logic                 reads_vs2;
  logic                 hazard;
  logic                 advance;
  logic                 wr_en;

  ////////////////////
  // Stage one
  ////////////////////

  assign vs1_elem = vrf_q[cur_q.vs1][idx_q];
  assign vs2_elem = vrf_q[cur_q.vs2][idx_q];
  assign in_range = idx_q < cur_q.vl;
  // SETVL and empty vl give a single beat
  assign last = (cur_q.kind == vec_isa_pkg::KIND_SETVL) || (cur_q.vl == '0) ||
                (idx_q == cur_q.vl - 1'b1);

  assign reads_vs2 = cur_q.kind != vec_isa_pkg::KIND_SETVL;
  assign reads_vs1 = (cur_q.kind == vec_isa_pkg::KIND_ARITH) && !cur_q.scalar_op;

  // Any write-back seen at element 0 comes from the previous instruction
  assign hazard = wb_valid_q && (idx_q == '0) &&
                  ((reads_vs2 && cur_q.vs2 == wb_q.vd) || (reads_vs1 && cur_q.vs1 == wb_q.vd));

  assign elem_valid_o  = busy_q && !hazard;
  assign advance       = elem_valid_o && elem_ready_i;
  assign issue_ready_o = !busy_q || (advance && last);
  // Tail stays undisturbed
  assign wr_en = advance && (cur_q.kind == vec_isa_pkg::KIND_ARITH) && in_range;

  always_comb begin
    alu_op = vec_isa_pkg::OP_ADD;
    alu_a  = in_range ? vs2_elem : '0;
    alu_b  = '0;
    if (cur_q.kind == vec_isa_pkg::KIND_ARITH) begin
      alu_op = cur_q.op;
      alu_b  = cur_q.scalar_op ? cur_q.scalar : vs1_elem;
    end else if (idx_q == '0) begin
      // Reduction seed
      alu_b = cur_q.scalar;
    end
  end

  vec_alu i_alu (
    .op_i  (alu_op ),
    .a_i   (alu_a  ),
    .b_i   (alu_b  ),
    .res_o (alu_res)
  );

  always_comb begin
    elem_o.kind = cur_q.kind;
    elem_o.last = last;
    case (cur_q.kind)
      vec_isa_pkg::KIND_SETVL: elem_o.data = vec_cfg_pkg::elem_t'(cur_q.vl);
      vec_isa_pkg::KIND_MOVX:  elem_o.data = vrf_q[cur_q.vs2][0];
      default:                 elem_o.data = alu_res;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
      idx_q  <= '0;
    end else if (issue_valid_i && issue_ready_o) begin
      busy_q <= 1'b1;
      idx_q  <= '0;
    end else if (advance) begin
      if (last) begin
        busy_q <= 1'b0;
      end else begin
        idx_q <= idx_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue_valid_i && issue_ready_o) begin
      cur_q <= issue_i;
    end
  end

  ////////////////////
  // Stage two
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wb_valid_q <= 1'b0;
    end else begin
      wb_valid_q <= wr_en;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      wb_q <= '{vd: cur_q.vd, idx: idx_q, data: alu_res};
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      vrf_q <= '0;
    end else if (wb_valid_q) begin
      vrf_q[wb_q.vd][wb_q.idx] <= wb_q.data;
    end
  end

  // Write-back index lies below the vl of its instruction
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wb_valid_q |-> wb_q.idx < $past(cur_q.vl));

endmodule

// ==== design/vec_result_unit.sv ====
module vec_result_unit (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  vec_isa_pkg::elem_res_t elem_i,
  input  logic                   elem_valid_i,
  output logic                   elem_ready_o,
  output vec_isa_pkg::acc_resp_t acc_resp_o,
  output logic                   acc_resp_valid_o,
  input  logic                   acc_resp_ready_i
);

  vec_cfg_pkg::elem_t     acc_q;
  vec_cfg_pkg::elem_t     elem0_q;
  vec_cfg_pkg::elem_t     red_sum;
  vec_cfg_pkg::elem_t     elem0;
  logic                   first_q;
  logic                   elem_hs;
  vec_isa_pkg::acc_resp_t resp_d;
  vec_isa_pkg::acc_resp_t pend_q;
  logic                   pend_valid_q;

  vec_isa_pkg::acc_resp_t fifo_q [vec_cfg_pkg::RESP_FIFO_DEPTH];
  vec_cfg_pkg::resp_ptr_t wr_ptr_q;
  vec_cfg_pkg::resp_ptr_t rd_ptr_q;
  vec_cfg_pkg::resp_cnt_t cnt_q;
  logic                   push;
  logic                   pop;

  function automatic vec_cfg_pkg::resp_ptr_t ptr_next(input vec_cfg_pkg::resp_ptr_t ptr);
    if (ptr == vec_cfg_pkg::resp_ptr_t'(vec_cfg_pkg::RESP_FIFO_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // Room is reserved for a response still in the pending slot
  assign elem_ready_o = (cnt_q + pend_valid_q) < vec_cfg_pkg::RESP_FIFO_DEPTH;
  assign elem_hs      = elem_valid_i && elem_ready_o;

  ////////////////////
  // Response forming
  ////////////////////

  always_comb begin
    // First beat of a reduction already carries rs1
    red_sum     = (first_q ? '0 : acc_q) + elem_i.data;
    elem0       = first_q ? elem_i.data : elem0_q;
    resp_d.kind = elem_i.kind;
    case (elem_i.kind)
      vec_isa_pkg::KIND_SETVL:  resp_d.data = elem_i.data;
      vec_isa_pkg::KIND_REDSUM: resp_d.data = red_sum;
      vec_isa_pkg::KIND_MOVX:   resp_d.data = elem0;
      default:                  resp_d.data = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      first_q      <= 1'b1;
      acc_q        <= '0;
      elem0_q      <= '0;
      pend_valid_q <= 1'b0;
    end else begin
      pend_valid_q <= elem_hs && elem_i.last;
      if (elem_hs) begin
        first_q <= elem_i.last;
        acc_q   <= red_sum;
        elem0_q <= elem0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (elem_hs && elem_i.last) begin
      pend_q <= resp_d;
    end
  end

  ////////////////////
  // Response FIFO
  ////////////////////

  assign push             = pend_valid_q;
  assign pop              = acc_resp_valid_o && acc_resp_ready_i;
  assign acc_resp_valid_o = cnt_q != '0;
  assign acc_resp_o       = fifo_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
      cnt_q <= cnt_q + vec_cfg_pkg::resp_cnt_t'(push) - vec_cfg_pkg::resp_cnt_t'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      fifo_q[wr_ptr_q] <= pend_q;
    end
  end

  // Pending response always finds a free entry
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    push |-> cnt_q < vec_cfg_pkg::RESP_FIFO_DEPTH);

endmodule

// ==== design/vec_unit.sv ====
module vec_unit (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  // Host interface
  input  vec_isa_pkg::acc_req_t  acc_req_i,
  input  logic                   acc_req_valid_i,
  output logic                   acc_req_ready_o,
  output vec_isa_pkg::acc_resp_t acc_resp_o,
  output logic                   acc_resp_valid_o,
  input  logic                   acc_resp_ready_i
);

  ////////////////////
  // Dispatcher
  ////////////////////

  vec_isa_pkg::vec_issue_t issue;
  logic                    issue_valid;
  logic                    issue_ready;

  vec_dispatcher i_dispatcher (
    .clk_i           (clk_i          ),
    .rst_n_i         (rst_n_i        ),
    .acc_req_i       (acc_req_i      ),
    .acc_req_valid_i (acc_req_valid_i),
    .acc_req_ready_o (acc_req_ready_o),
    .issue_o         (issue          ),
    .issue_valid_o   (issue_valid    ),
    .issue_ready_i   (issue_ready    )
  );

  ////////////////////
  // Lane
  ////////////////////

  vec_isa_pkg::elem_res_t elem;
  logic                   elem_valid;
  logic                   elem_ready;

  vec_lane i_lane (
    .clk_i         (clk_i      ),
    .rst_n_i       (rst_n_i    ),
    .issue_i       (issue      ),
    .issue_valid_i (issue_valid),
    .issue_ready_o (issue_ready),
    .elem_o        (elem       ),
    .elem_valid_o  (elem_valid ),
    .elem_ready_i  (elem_ready )
  );

  // Result unit
  vec_result_unit i_result_unit (
    .clk_i            (clk_i           ),
    .rst_n_i          (rst_n_i         ),
    .elem_i           (elem            ),
    .elem_valid_i     (elem_valid      ),
    .elem_ready_o     (elem_ready      ),
    .acc_resp_o       (acc_resp_o      ),
    .acc_resp_valid_o (acc_resp_valid_o),
    .acc_resp_ready_i (acc_resp_ready_i)
  );

endmodule

// ==== test/vec_checker.sv ====
module vec_checker (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  // Expected responses, one per pulse
  input  logic                   exp_push_i,
  input  vec_isa_pkg::acc_resp_t exp_resp_i,
  // Observed response port of the DUT
  input  vec_isa_pkg::acc_resp_t acc_resp_i,
  input  logic                   acc_resp_valid_i,
  input  logic                   acc_resp_ready_i,
  output int                     pass_cnt_o,
  output int                     fail_cnt_o,
  output int                     pending_o
);

  vec_isa_pkg::acc_resp_t exp_q [$];
  vec_isa_pkg::acc_resp_t exp;
  int                     resp_idx;
  logic                   ok;

  initial begin
    pass_cnt_o = 0;
    fail_cnt_o = 0;
    pending_o  = 0;
    resp_idx   = 0;
  end

  // Compare on every response handshake
  always @(posedge clk_i) begin
    if (rst_n_i && acc_resp_valid_i && exp_q.size() == 0) begin
      // Valid must stay low until a result is due
      $display("Unexpected response: acc_resp_valid_o high while no result is expected");
      fail_cnt_o = fail_cnt_o + 1;
    end else if (rst_n_i && acc_resp_valid_i && acc_resp_ready_i) begin
      exp = exp_q.pop_front();
      ok  = 1'b1;
      if (acc_resp_i.kind !== exp.kind) begin
        $display("FAILED test %0d: acc_resp_o.kind expected 0x%0h got 0x%0h",
                 resp_idx, exp.kind, acc_resp_i.kind);
        ok = 1'b0;
      end
      if (acc_resp_i.data !== exp.data) begin
        $display("FAILED test %0d: acc_resp_o.data expected 0x%08h got 0x%08h",
                 resp_idx, exp.data, acc_resp_i.data);
        ok = 1'b0;
      end
      if (ok) begin
        $display("Test %0d passed: kind 0x%0h data 0x%08h",
                 resp_idx, acc_resp_i.kind, acc_resp_i.data);
        pass_cnt_o = pass_cnt_o + 1;
      end else begin
        fail_cnt_o = fail_cnt_o + 1;
      end
      resp_idx = resp_idx + 1;
    end
    if (exp_push_i) begin
      exp_q.push_back(exp_resp_i);
    end
    pending_o = exp_q.size();
  end

endmodule

// ==== test/tb_vec_unit.sv ====
module tb_vec_unit;

  typedef struct packed {
    vec_isa_pkg::acc_req_t  req;
    vec_isa_pkg::acc_resp_t exp;
  } test_t;

  logic                   clk;
  logic                   rst_n;
  vec_isa_pkg::acc_req_t  acc_req;
  logic                   acc_req_valid;
  logic                   acc_req_ready;
  vec_isa_pkg::acc_resp_t acc_resp;
  logic                   acc_resp_valid;
  logic                   acc_resp_ready;
  logic                   exp_push;
  vec_isa_pkg::acc_resp_t exp_resp;
  int                     pass_cnt;
  int                     fail_cnt;
  int                     pending;

  test_t tbl [$];
  bit    tbl_built;
  int    tb_errors;
  int    seed;
  logic  accepted;

  vec_unit dut0 (
    .clk_i            (clk           ),
    .rst_n_i          (rst_n         ),
    .acc_req_i        (acc_req       ),
    .acc_req_valid_i  (acc_req_valid ),
    .acc_req_ready_o  (acc_req_ready ),
    .acc_resp_o       (acc_resp      ),
    .acc_resp_valid_o (acc_resp_valid),
    .acc_resp_ready_i (acc_resp_ready)
  );

  vec_checker chk0 (
    .clk_i            (clk           ),
    .rst_n_i          (rst_n         ),
    .exp_push_i       (exp_push      ),
    .exp_resp_i       (exp_resp      ),
    .acc_resp_i       (acc_resp      ),
    .acc_resp_valid_i (acc_resp_valid),
    .acc_resp_ready_i (acc_resp_ready),
    .pass_cnt_o       (pass_cnt      ),
    .fail_cnt_o       (fail_cnt      ),
    .pending_o        (pending       )
  );

  ////////////////////
  // Table rows
  ////////////////////

  task automatic set_length(input logic [4:0] avl, input vec_cfg_pkg::elem_t exp_vl);
    test_t t;
    t                  = '0;
    t.req.insn.cfg.kind = vec_isa_pkg::KIND_SETVL;
    t.req.insn.cfg.avl  = avl;
    t.exp.kind         = vec_isa_pkg::KIND_SETVL;
    t.exp.data         = exp_vl;
    tbl.push_back(t);
  endtask

  // Element results land in vd, the response itself is always 0
  task automatic compute(input vec_isa_pkg::alu_op_e op, input vec_cfg_pkg::vreg_idx_t vd,
                         input vec_cfg_pkg::vreg_idx_t vs2, input vec_cfg_pkg::vreg_idx_t vs1,
                         input logic scalar_op, input vec_cfg_pkg::elem_t rs1);
    test_t t;
    t                         = '0;
    t.req.insn.arith.kind      = vec_isa_pkg::KIND_ARITH;
    t.req.insn.arith.op        = op;
    t.req.insn.arith.vd        = vd;
    t.req.insn.arith.vs1       = vs1;
    t.req.insn.arith.vs2       = vs2;
    t.req.insn.arith.scalar_op = scalar_op;
    t.req.rs1                 = rs1;
    t.exp.kind                = vec_isa_pkg::KIND_ARITH;
    t.exp.data                = '0;
    tbl.push_back(t);
  endtask

  task automatic reduce_sum(input vec_cfg_pkg::vreg_idx_t vs2, input vec_cfg_pkg::elem_t rs1,
                            input vec_cfg_pkg::elem_t sum);
    test_t t;
    t                    = '0;
    t.req.insn.arith.kind = vec_isa_pkg::KIND_REDSUM;
    t.req.insn.arith.vs2  = vs2;
    t.req.rs1            = rs1;
    t.exp.kind           = vec_isa_pkg::KIND_REDSUM;
    t.exp.data           = sum;
    tbl.push_back(t);
  endtask

  task automatic move_scalar(input vec_cfg_pkg::vreg_idx_t vs2, input vec_cfg_pkg::elem_t elem0);
    test_t t;
    t                    = '0;
    t.req.insn.arith.kind = vec_isa_pkg::KIND_MOVX;
    t.req.insn.arith.vs2  = vs2;
    t.exp.kind           = vec_isa_pkg::KIND_MOVX;
    t.exp.data           = elem0;
    tbl.push_back(t);
  endtask

  task automatic build_table();
    // Reset vl is VLMAX, v1 becomes 5 everywhere
    compute(vec_isa_pkg::OP_MV, 3'd1, 3'd0, 3'd0, 1'b1, 32'h5);
    reduce_sum(3'd1, 32'h0, 32'h28);
    set_length(5'd3, 32'd3);
    set_length(5'd8, 32'd8);
    set_length(5'd20, 32'd8);
    // Splats, v2 = f0 and v3 = 3c
    compute(vec_isa_pkg::OP_MV, 3'd2, 3'd0, 3'd0, 1'b1, 32'hf0);
    move_scalar(3'd2, 32'hf0);
    compute(vec_isa_pkg::OP_MV, 3'd3, 3'd0, 3'd0, 1'b1, 32'h3c);
    // Vector-vector, sums are 8 times the element
    compute(vec_isa_pkg::OP_ADD, 3'd4, 3'd2, 3'd3, 1'b0, 32'h0);
    reduce_sum(3'd4, 32'h0, 8 * 32'h12c);
    compute(vec_isa_pkg::OP_SUB, 3'd4, 3'd2, 3'd3, 1'b0, 32'h0);
    reduce_sum(3'd4, 32'h0, 8 * 32'hb4);
    compute(vec_isa_pkg::OP_AND, 3'd5, 3'd2, 3'd3, 1'b0, 32'h0);
    reduce_sum(3'd5, 32'h0, 8 * 32'h30);
    compute(vec_isa_pkg::OP_OR, 3'd5, 3'd2, 3'd3, 1'b0, 32'h0);
    reduce_sum(3'd5, 32'h0, 8 * 32'hfc);
    compute(vec_isa_pkg::OP_XOR, 3'd6, 3'd2, 3'd3, 1'b0, 32'h0);
    reduce_sum(3'd6, 32'h0, 8 * 32'hcc);
    // Vector-scalar against v2
    compute(vec_isa_pkg::OP_ADD, 3'd7, 3'd2, 3'd0, 1'b1, 32'h10);
    reduce_sum(3'd7, 32'h0, 8 * 32'h100);
    compute(vec_isa_pkg::OP_SUB, 3'd7, 3'd2, 3'd0, 1'b1, 32'hf1);
    reduce_sum(3'd7, 32'h0, 32'hffff_fff8);
    compute(vec_isa_pkg::OP_AND, 3'd7, 3'd2, 3'd0, 1'b1, 32'hff);
    reduce_sum(3'd7, 32'h0, 8 * 32'hf0);
    compute(vec_isa_pkg::OP_OR, 3'd7, 3'd2, 3'd0, 1'b1, 32'h0f);
    reduce_sum(3'd7, 32'h0, 8 * 32'hff);
    compute(vec_isa_pkg::OP_XOR, 3'd7, 3'd2, 3'd0, 1'b1, 32'hff);
    reduce_sum(3'd7, 32'h0, 8 * 32'h0f);
    reduce_sum(3'd1, 32'h64, 32'h64 + 8 * 32'h5);
    // Partial vl, the tail of v1 keeps 5
    set_length(5'd3, 32'd3);
    compute(vec_isa_pkg::OP_ADD, 3'd1, 3'd1, 3'd3, 1'b0, 32'h0);
    move_scalar(3'd1, 32'h41);
    set_length(5'd0, 32'd0);
    compute(vec_isa_pkg::OP_XOR, 3'd1, 3'd1, 3'd1, 1'b0, 32'h0);
    move_scalar(3'd1, 32'h41);
    set_length(5'd8, 32'd8);
    reduce_sum(3'd1, 32'h0, 3 * 32'h41 + 5 * 32'h5);
  endtask

  ////////////////////
  // Clock and back-pressure
  ////////////////////

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    seed = 32'h9afc_c55c;
    void'($urandom(seed));
    wait (rst_n);
    forever begin
      @(negedge clk);
      acc_resp_ready = ($urandom % 4) != 0;
    end
  end

  // Watchdog scaled to the table length
  initial begin
    wait (tbl_built);
    repeat (tbl.size() * (vec_cfg_pkg::VLMAX + 10) + 100) @(posedge clk);
    $display("Timeout: the DUT did not deliver every expected response in time");
    $display("Finished with errors");
    $finish;
  end

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    rst_n          = 1'b0;
    acc_req        = '0;
    acc_req_valid  = 1'b0;
    acc_resp_ready = 1'b1;
    exp_push       = 1'b0;
    exp_resp       = '0;
    tb_errors      = 0;
    build_table();
    tbl_built = 1'b1;

    repeat (3) begin
      @(posedge clk);
      if (acc_resp_valid !== 1'b0) begin
        $display("Response valid is high during reset");
        tb_errors++;
      end
    end
    @(negedge clk);
    rst_n = 1'b1;
    @(posedge clk);
    if (acc_req_ready !== 1'b1 || acc_resp_valid !== 1'b0) begin
      $display("Request ready low or response valid high right after reset");
      tb_errors++;
    end

    // Requests go out back to back on falling edges
    @(negedge clk);
    foreach (tbl[i]) begin
      acc_req       = tbl[i].req;
      acc_req_valid = 1'b1;
      exp_resp      = tbl[i].exp;
      exp_push      = 1'b1;
      do begin
        @(posedge clk);
        accepted = acc_req_ready;
        @(negedge clk);
        exp_push = 1'b0;
      end while (!accepted);
    end
    acc_req_valid = 1'b0;

    while (pending != 0) begin
      @(negedge clk);
    end
    repeat (4) @(negedge clk);

    $display("Summary: %0d passed, %0d failed of %0d tests",
             pass_cnt, fail_cnt + tb_errors, tbl.size());
    if (fail_cnt + tb_errors == 0 && pass_cnt == tbl.size()) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// ==== list.f ====
design/vec_cfg_pkg.sv
design/vec_isa_pkg.sv
design/vec_alu.sv
design/vec_dispatcher.sv
design/vec_lane.sv
design/vec_result_unit.sv
design/vec_unit.sv
test/vec_checker.sv
test/tb_vec_unit.sv

// ==== Bender.yml ====
package:
  name: vec_unit

sources:
  - files:
      - design/vec_cfg_pkg.sv
      - design/vec_isa_pkg.sv
      - design/vec_alu.sv
      - design/vec_dispatcher.sv
      - design/vec_lane.sv
      - design/vec_result_unit.sv
      - design/vec_unit.sv
  - target: test
    files:
      - test/vec_checker.sv
      - test/tb_vec_unit.sv
